// File: sources.f
src/rob_pkg.sv
src/rob_ctrl.sv
src/rob_entry.sv
src/rob_regfile.sv
src/rob_top.sv
tb/rob_checker.sv
tb/rob_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the ROB testbench with Verilator, run it, and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f sources.f --top-module rob_tb -o rob_sim \
   && ./obj_dir/rob_sim 2>&1 | tee /dev/stderr | grep "Simulation PASSED" > /dev/null \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }

// File: tb/rob_tb.sv
`timescale 1ns/1ps

module rob_tb
   import rob_pkg::*;
();

   localparam int RESET_CYCLES   = 5;
   localparam int RAND_CYCLES    = 200;
   // Budgets per test, reset through random traffic with its drain and readback
   localparam int TEST_CYCLES    = 10 + 40 + 60 + 30 + 40 + (RAND_CYCLES + 120);
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 200;

   logic      clk;
   logic      rst_n;
   logic      alloc_valid;
   ent_kind_e alloc_kind;
   logic      alloc_dst_en;
   reg_addr_t alloc_dst;
   rob_id_t   alloc_id;
   logic      full;
   logic      cmpl_valid;
   rob_id_t   cmpl_id;
   xlen_t     cmpl_result;
   logic      cmpl_mispred;
   logic      retire_valid;
   rob_id_t   retire_id;
   logic      retire_dst_en;
   reg_addr_t retire_dst;
   xlen_t     retire_data;
   logic      br_mispred;
   xlen_t     br_tgt;
   reg_addr_t rd_addr_a;
   xlen_t     rd_data_a;
   reg_addr_t rd_addr_b;
   xlen_t     rd_data_b;

   // Reference model, one slot per ROB entry
   ent_state_e m_state  [ROB_ENTRIES];
   ent_kind_e  m_kind   [ROB_ENTRIES];
   logic       m_dst_en [ROB_ENTRIES];
   reg_addr_t  m_dst    [ROB_ENTRIES];
   xlen_t      m_res    [ROB_ENTRIES];
   logic       m_mis    [ROB_ENTRIES];
   rob_id_t    rob_q[$];   // ids in program order
   rob_id_t    m_tail;
   xlen_t      ref_regs [NUM_REGS];
   int         retire_cnt;
   int         flush_cnt;
   int         cycle_cnt;

   rob_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic check_id(input string name, input rob_id_t got, input rob_id_t exp);
      if (got !== exp) begin
         fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
      if (got !== exp) begin
         fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
      if (got !== exp) begin
         fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYCLES) begin
         fail_run("Timeout, the run hung before all tests finished");
      end
   end

   // Model checks this cycle's outputs, then steps on this cycle's inputs
   always @(negedge clk) begin : model_step
      rob_id_t hid;
      logic    exp_ret;
      logic    exp_flush;
      logic    was_full;
      if (rst_n) begin
         hid      = '0;
         exp_ret  = 1'b0;
         was_full = (rob_q.size() == ROB_ENTRIES);
         if (rob_q.size() != 0) begin
            hid     = rob_q[0];
            exp_ret = (m_state[hid] == ENT_DONE);
         end
         exp_flush = exp_ret && (m_kind[hid] == KIND_BRANCH) && m_mis[hid];
         check_bit("retire_valid", retire_valid, exp_ret);
         check_bit("br_mispred", br_mispred, exp_flush);
         check_bit("full", full, was_full);
         check_id("alloc_id", alloc_id, m_tail);
         if (exp_ret) begin
            check_id("retire_id", retire_id, hid);
            check_bit("retire_dst_en", retire_dst_en, m_dst_en[hid]);
            check_addr("retire_dst", retire_dst, m_dst[hid]);
            check_data("retire_data", retire_data, m_res[hid]);
            if (m_dst_en[hid] && (m_dst[hid] != '0)) begin
               ref_regs[m_dst[hid]] = m_res[hid];
            end
            m_state[hid] = ENT_FREE;
            void'(rob_q.pop_front());
            retire_cnt++;
         end
         if (exp_flush) begin
            check_data("br_tgt", br_tgt, m_res[hid]);
            foreach (rob_q[i]) begin
               m_state[rob_q[i]] = ENT_FREE;
            end
            rob_q.delete();
            m_tail = hid + rob_id_t'(1);
            flush_cnt++;
         end else begin
            if (cmpl_valid && (m_state[cmpl_id] == ENT_WAIT)) begin
               m_state[cmpl_id] = ENT_DONE;
               m_res[cmpl_id]   = cmpl_result;
               m_mis[cmpl_id]   = cmpl_mispred;
            end
            if (alloc_valid && !was_full) begin
               m_state[m_tail]  = ENT_WAIT;
               m_kind[m_tail]   = alloc_kind;
               m_dst_en[m_tail] = alloc_dst_en;
               m_dst[m_tail]    = alloc_dst;
               rob_q.push_back(m_tail);
               m_tail = m_tail + rob_id_t'(1);
            end
         end
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      alloc_valid <= 1'b0;
      cmpl_valid  <= 1'b0;
   endtask

   task automatic alloc_one(input ent_kind_e k, input logic de, input reg_addr_t d);
      next_cycle();
      alloc_valid  <= 1'b1;
      alloc_kind   <= k;
      alloc_dst_en <= de;
      alloc_dst    <= d;
   endtask

   task automatic complete_one(input rob_id_t id, input xlen_t res, input logic mis);
      next_cycle();
      cmpl_valid   <= 1'b1;
      cmpl_id      <= id;
      cmpl_result  <= res;
      cmpl_mispred <= mis;
   endtask

   task automatic drain();
      next_cycle();
      while (rob_q.size() != 0) begin
         next_cycle();
      end
   endtask

   task automatic read_check(input int a, input int b,
                             input xlen_t exp_a, input xlen_t exp_b);
      next_cycle();
      rd_addr_a <= reg_addr_t'(a);
      rd_addr_b <= reg_addr_t'(b);
      @(negedge clk);
      check_data("rd_data_a", rd_data_a, exp_a);
      check_data("rd_data_b", rd_data_b, exp_b);
   endtask

   task automatic test_reset();
      @(negedge clk);
      check_bit("full", full, 1'b0);
      check_bit("retire_valid", retire_valid, 1'b0);
      check_bit("br_mispred", br_mispred, 1'b0);
      check_id("alloc_id", alloc_id, '0);
      check_data("rd_data_a", rd_data_a, '0);
      check_data("rd_data_b", rd_data_b, '0);
   endtask

   task automatic test_in_order();
      rob_id_t first;
      int      base_ret;
      next_cycle();
      first    = m_tail;
      base_ret = retire_cnt;
      for (int i = 0; i < 4; i++) begin
         alloc_one(KIND_ALU, 1'b1, reg_addr_t'(i + 1));
      end
      // Youngest first, so retirement has to wait on the head
      for (int i = 3; i >= 0; i--) begin
         complete_one(rob_id_t'(first + i), 32'hC0DE_0000 + xlen_t'(i), 1'b0);
      end
      drain();
      if (retire_cnt != base_ret + 4) begin
         fail_run("In-order test did not retire all four entries");
      end
      for (int i = 0; i < 4; i++) begin
         read_check(i + 1, 0, 32'hC0DE_0000 + xlen_t'(i), '0);
      end
   endtask

   task automatic test_full();
      rob_id_t head_id;
      next_cycle();
      head_id = m_tail;
      for (int i = 0; i < ROB_ENTRIES; i++) begin
         alloc_one(KIND_ALU, 1'b1, reg_addr_t'(i + 8));
      end
      next_cycle();
      @(negedge clk);
      check_bit("full", full, 1'b1);
      check_id("alloc_id", alloc_id, head_id);
      // Strobe while full must be dropped
      alloc_one(KIND_BRANCH, 1'b1, 5'd20);
      next_cycle();
      @(negedge clk);
      check_bit("full", full, 1'b1);
      check_id("alloc_id", alloc_id, head_id);
      complete_one(head_id, 32'h5500_0000, 1'b0);
      next_cycle();
      @(negedge clk);
      check_bit("retire_valid", retire_valid, 1'b1);
      next_cycle();
      @(negedge clk);
      check_bit("full", full, 1'b0);
      for (int i = 1; i < ROB_ENTRIES; i++) begin
         complete_one(rob_id_t'(head_id + i), 32'h5500_0000 + xlen_t'(i), 1'b0);
      end
      drain();
   endtask

   task automatic test_no_write();
      rob_id_t first;
      int      base_ret;
      next_cycle();
      first    = m_tail;
      base_ret = retire_cnt;
      alloc_one(KIND_ALU, 1'b0, 5'd3);
      alloc_one(KIND_ALU, 1'b1, 5'd0);
      complete_one(first, 32'hDEAD_0003, 1'b0);
      complete_one(rob_id_t'(first + 1), 32'hDEAD_0000, 1'b0);
      drain();
      if (retire_cnt != base_ret + 2) begin
         fail_run("Entries without a register write did not retire");
      end
      read_check(3, 0, 32'hC0DE_0002, '0);
   endtask

   task automatic test_flush();
      rob_id_t br_id;
      int      base_ret;
      int      base_flush;
      next_cycle();
      br_id      = m_tail;
      base_ret   = retire_cnt;
      base_flush = flush_cnt;
      alloc_one(KIND_BRANCH, 1'b0, '0);
      alloc_one(KIND_ALU, 1'b1, 5'd20);
      alloc_one(KIND_ALU, 1'b1, 5'd21);
      complete_one(rob_id_t'(br_id + 1), 32'h2020_2020, 1'b0);
      complete_one(rob_id_t'(br_id + 2), 32'h2121_2121, 1'b0);
      complete_one(br_id, 32'h0000_4000, 1'b1);
      next_cycle();
      @(negedge clk);
      check_bit("br_mispred", br_mispred, 1'b1);
      check_data("br_tgt", br_tgt, 32'h0000_4000);
      drain();
      if (retire_cnt != base_ret + 1 || flush_cnt != base_flush + 1) begin
         fail_run("Mispredicted branch did not flush its younger entries");
      end
      @(negedge clk);
      check_id("alloc_id", alloc_id, rob_id_t'(br_id + 1));
      read_check(20, 21, '0, '0);
   endtask

   task automatic complete_random(input int pct);
      rob_id_t waiting[$];
      rob_id_t id;
      foreach (m_state[i]) begin
         if (m_state[i] == ENT_WAIT) begin
            waiting.push_back(rob_id_t'(i));
         end
      end
      if (waiting.size() != 0 && $urandom_range(0, 99) < pct) begin
         id = waiting[$urandom_range(0, waiting.size() - 1)];
         cmpl_valid   <= 1'b1;
         cmpl_id      <= id;
         cmpl_result  <= $urandom;
         cmpl_mispred <= (m_kind[id] == KIND_BRANCH) && ($urandom_range(0, 2) == 0);
      end
   endtask

   task automatic test_random();
      for (int c = 0; c < RAND_CYCLES; c++) begin
         next_cycle();
         if ($urandom_range(0, 99) < 55) begin
            alloc_valid  <= 1'b1;
            alloc_kind   <= KIND_ALU;
            if ($urandom_range(0, 4) == 0) begin
               alloc_kind <= KIND_BRANCH;
            end
            alloc_dst_en <= ($urandom_range(0, 7) != 0);
            alloc_dst    <= reg_addr_t'($urandom_range(0, NUM_REGS - 1));
         end
         complete_random(50);
      end
      next_cycle();
      while (rob_q.size() != 0) begin
         complete_random(100);
         next_cycle();
      end
      foreach (ref_regs[i]) begin
         read_check(i, NUM_REGS - 1 - i, ref_regs[i], ref_regs[NUM_REGS - 1 - i]);
      end
   endtask

   initial begin
      void'($urandom(32'h4d5f));
      rst_n        = 1'b0;
      alloc_valid  = 1'b0;
      alloc_kind   = KIND_ALU;
      alloc_dst_en = 1'b0;
      alloc_dst    = '0;
      cmpl_valid   = 1'b0;
      cmpl_id      = '0;
      cmpl_result  = '0;
      cmpl_mispred = 1'b0;
      rd_addr_a    = 5'd1;
      rd_addr_b    = 5'd31;
      m_tail       = '0;
      retire_cnt   = 0;
      flush_cnt    = 0;
      cycle_cnt    = 0;
      foreach (m_state[i]) begin
         m_state[i] = ENT_FREE;
      end
      foreach (ref_regs[i]) begin
         ref_regs[i] = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      test_reset();
      test_in_order();
      test_full();
      test_no_write();
      test_flush();
      test_random();
      $display("%0d retirements, %0d flushes", retire_cnt, flush_cnt);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: tb/rob_checker.sv
`timescale 1ns/1ps

module rob_checker
   import rob_pkg::*;
(
   input logic                   clk,
   input logic                   rst_n,
   input logic [ROB_ENTRIES-1:0] ent_alloc,
   input logic [ROB_ENTRIES-1:0] ent_cmpl,
   input logic [ROB_ENTRIES-1:0] ent_retire,
   input logic                   retire_valid,
   input logic                   br_mispred,
   input logic                   rf_wr_en,
   input reg_addr_t              rf_wr_addr,
   input rob_ptr_t               head,
   input rob_ptr_t               tail
);

   // Each strobe vector selects at most one entry
   a_alloc_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ent_alloc))
      else $error("ent_alloc has more than one bit set");

   a_cmpl_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ent_cmpl))
      else $error("ent_cmpl has more than one bit set");

   a_retire_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ent_retire))
      else $error("ent_retire has more than one bit set");

   // A redirect only comes with a retirement
   a_mispred_retire: assert property (@(posedge clk) disable iff (!rst_n)
      br_mispred |-> retire_valid)
      else $error("br_mispred high without retire_valid");

   a_no_retire_empty: assert property (@(posedge clk) disable iff (!rst_n)
      (head == tail) |-> !retire_valid)
      else $error("retire_valid high while the ROB is empty");

   // x0 is hardwired
   a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
      rf_wr_en |-> (rf_wr_addr != '0))
      else $error("register file write aimed at x0");

endmodule

bind rob_ctrl rob_checker u_checker (
   .clk          (clk),
   .rst_n        (rst_n),
   .ent_alloc    (ent_alloc),
   .ent_cmpl     (ent_cmpl),
   .ent_retire   (ent_retire),
   .retire_valid (retire_valid),
   .br_mispred   (br_mispred),
   .rf_wr_en     (rf_wr_en),
   .rf_wr_addr   (rf_wr_addr),
   .head         (head),
   .tail         (tail)
);

// File: src/rob_top.sv
`timescale 1ns/1ps

module rob_top
   import rob_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   input  logic      alloc_valid,
   input  ent_kind_e alloc_kind,
   input  logic      alloc_dst_en,
   input  reg_addr_t alloc_dst,
   output rob_id_t   alloc_id,
   output logic      full,

   input  logic      cmpl_valid,
   input  rob_id_t   cmpl_id,
   input  xlen_t     cmpl_result,
   input  logic      cmpl_mispred,

   output logic      retire_valid,
   output rob_id_t   retire_id,
   output logic      retire_dst_en,
   output reg_addr_t retire_dst,
   output xlen_t     retire_data,

   output logic      br_mispred,
   output xlen_t     br_tgt,

   input  reg_addr_t rd_addr_a,
   output xlen_t     rd_data_a,
   input  reg_addr_t rd_addr_b,
   output xlen_t     rd_data_b
);

   logic [ROB_ENTRIES-1:0] ent_alloc;
   logic [ROB_ENTRIES-1:0] ent_cmpl;
   logic [ROB_ENTRIES-1:0] ent_retire;
   logic                   flush;

   ent_state_e             ent_state   [ROB_ENTRIES-1:0];
   ent_kind_e              ent_kind    [ROB_ENTRIES-1:0];
   logic                   ent_dst_en  [ROB_ENTRIES-1:0];
   reg_addr_t              ent_dst     [ROB_ENTRIES-1:0];
   xlen_t                  ent_result  [ROB_ENTRIES-1:0];
   logic                   ent_mispred [ROB_ENTRIES-1:0];

   logic                   rf_wr_en;
   reg_addr_t              rf_wr_addr;
   xlen_t                  rf_wr_data;

   rob_ctrl u_ctrl (
      .clk,
      .rst_n,
      .alloc_valid,
      .full,
      .alloc_id,
      .cmpl_valid,
      .cmpl_id,
      .ent_state,
      .ent_kind,
      .ent_dst_en,
      .ent_dst,
      .ent_result,
      .ent_mispred,
      .ent_alloc,
      .ent_cmpl,
      .ent_retire,
      .flush,
      .retire_valid,
      .retire_id,
      .retire_dst_en,
      .retire_dst,
      .retire_data,
      .br_mispred,
      .br_tgt,
      .rf_wr_en,
      .rf_wr_addr,
      .rf_wr_data
   );

   for (genvar i = 0; i < ROB_ENTRIES; i++) begin : g_ents
      rob_entry u_ent (
         .clk,
         .rst_n,
         .alloc        (ent_alloc[i]),
         .alloc_kind,
         .alloc_dst_en,
         .alloc_dst,
         .cmpl         (ent_cmpl[i]),
         .cmpl_result,
         .cmpl_mispred,
         .retire       (ent_retire[i]),
         .flush,
         .state        (ent_state[i]),
         .kind         (ent_kind[i]),
         .dst_en       (ent_dst_en[i]),
         .dst          (ent_dst[i]),
         .result       (ent_result[i]),
         .mispred      (ent_mispred[i])
      );
   end

   rob_regfile u_rf (
      .clk,
      .rst_n,
      .wr_en   (rf_wr_en),
      .wr_addr (rf_wr_addr),
      .wr_data (rf_wr_data),
      .rd_addr_a,
      .rd_data_a,
      .rd_addr_b,
      .rd_data_b
   );

endmodule

// File: src/rob_regfile.sv
`timescale 1ns/1ps

module rob_regfile
   import rob_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   input  logic      wr_en,
   input  reg_addr_t wr_addr,
   input  xlen_t     wr_data,

   input  reg_addr_t rd_addr_a,
   output xlen_t     rd_data_a,
   input  reg_addr_t rd_addr_b,
   output xlen_t     rd_data_b
);

   xlen_t regs [NUM_REGS-1:0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_addr != '0)) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // Combinational reads, x0 forced to zero
   assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
   assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

// File: src/rob_entry.sv
`timescale 1ns/1ps

module rob_entry
   import rob_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,

   input  logic       alloc,
   input  ent_kind_e  alloc_kind,
   input  logic       alloc_dst_en,
   input  reg_addr_t  alloc_dst,

   input  logic       cmpl,
   input  xlen_t      cmpl_result,
   input  logic       cmpl_mispred,

   input  logic       retire,
   input  logic       flush,

   output ent_state_e state,
   output ent_kind_e  kind,
   output logic       dst_en,
   output reg_addr_t  dst,
   output xlen_t      result,
   output logic       mispred
);

   ent_state_e state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         ENT_FREE: begin
            if (alloc) state_nxt = ENT_WAIT;
         end
         ENT_WAIT: begin
            if (cmpl) state_nxt = ENT_DONE;
         end
         ENT_DONE: begin
            if (retire) state_nxt = ENT_FREE;
         end
         default: state_nxt = ENT_FREE;
      endcase
      // Flush wins over everything
      if (flush) state_nxt = ENT_FREE;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ENT_FREE;
      end else begin
         state <= state_nxt;
      end
   end

   // Static fields from decode
   always_ff @(posedge clk) begin
      if (alloc) begin
         kind   <= alloc_kind;
         dst_en <= alloc_dst_en;
         dst    <= alloc_dst;
      end
   end

   // Dynamic fields from execution
   always_ff @(posedge clk) begin
      if (cmpl) begin
         result  <= cmpl_result;
         mispred <= cmpl_mispred;
      end
   end

endmodule

// File: src/rob_ctrl.sv
`timescale 1ns/1ps

module rob_ctrl
   import rob_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,

   input  logic                   alloc_valid,
   output logic                   full,
   output rob_id_t                alloc_id,

   input  logic                   cmpl_valid,
   input  rob_id_t                cmpl_id,

   input  ent_state_e             ent_state   [ROB_ENTRIES-1:0],
   input  ent_kind_e              ent_kind    [ROB_ENTRIES-1:0],
   input  logic                   ent_dst_en  [ROB_ENTRIES-1:0],
   input  reg_addr_t              ent_dst     [ROB_ENTRIES-1:0],
   input  xlen_t                  ent_result  [ROB_ENTRIES-1:0],
   input  logic                   ent_mispred [ROB_ENTRIES-1:0],

   output logic [ROB_ENTRIES-1:0] ent_alloc,
   output logic [ROB_ENTRIES-1:0] ent_cmpl,
   output logic [ROB_ENTRIES-1:0] ent_retire,
   output logic                   flush,

   output logic                   retire_valid,
   output rob_id_t                retire_id,
   output logic                   retire_dst_en,
   output reg_addr_t              retire_dst,
   output xlen_t                  retire_data,

   output logic                   br_mispred,
   output xlen_t                  br_tgt,

   output logic                   rf_wr_en,
   output reg_addr_t              rf_wr_addr,
   output xlen_t                  rf_wr_data
);

   function automatic rob_ptr_t ptr_inc(input rob_ptr_t p);
      logic [ROB_ID_W:0] v;
      v = p + 1'b1;
      return rob_ptr_t'(v);
   endfunction

   function automatic logic [ROB_ENTRIES-1:0] onehot(input rob_id_t id);
      logic [ROB_ENTRIES-1:0] v;
      v = '0;
      v[id] = 1'b1;
      return v;
   endfunction

   rob_ptr_t head;   // oldest valid entry, when not empty
   rob_ptr_t tail;   // next entry to allocate, when not full

   logic     empty;
   logic     alloc_ok;
   logic     cmpl_ok;
   logic     head_done;

   assign empty = (head == tail);
   assign full  = (head.idx == tail.idx) && (head.wrap != tail.wrap);

   assign alloc_id = tail.idx;

   // Allocation is dropped while full or while the ROB is being flushed
   assign alloc_ok  = alloc_valid && !full && !flush;
   assign ent_alloc = alloc_ok ? onehot(tail.idx) : '0;

   // Stale or duplicate completions are ignored
   assign cmpl_ok  = cmpl_valid && (ent_state[cmpl_id] == ENT_WAIT);
   assign ent_cmpl = cmpl_ok ? onehot(cmpl_id) : '0;

   // Head select
   assign head_done     = (ent_state[head.idx] == ENT_DONE);
   assign retire_valid  = !empty && head_done;
   assign retire_id     = head.idx;
   assign retire_dst_en = ent_dst_en[head.idx];
   assign retire_dst    = ent_dst[head.idx];
   assign retire_data   = ent_result[head.idx];
   assign ent_retire    = retire_valid ? onehot(head.idx) : '0;

   // Mispredicted branch at head, younger work is discarded
   assign flush      = retire_valid && (ent_kind[head.idx] == KIND_BRANCH) &&
                       ent_mispred[head.idx];
   assign br_mispred = flush;
   assign br_tgt     = ent_result[head.idx];

   // x0 is hardwired, never written
   assign rf_wr_en   = retire_valid && retire_dst_en && (retire_dst != '0);
   assign rf_wr_addr = retire_dst;
   assign rf_wr_data = retire_data;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         head <= '0;
         tail <= '0;
      end else if (flush) begin
         // Both collapse to just past the branch
         head <= ptr_inc(head);
         tail <= ptr_inc(head);
      end else begin
         if (retire_valid) begin
            head <= ptr_inc(head);
         end
         if (alloc_ok) begin
            tail <= ptr_inc(tail);
         end
      end
   end

endmodule

// File: src/rob_pkg.sv
package rob_pkg;

   // Sizes
   localparam int ROB_ENTRIES = 8;
   localparam int ROB_ID_W    = 3;
   localparam int NUM_REGS    = 32;
   localparam int REG_ADDR_W  = 5;
   localparam int XLEN        = 32;

   // Entry index into the ROB
   typedef logic [ROB_ID_W-1:0] rob_id_t;

   // Head/tail pointer, wrap bit sits above the index
   typedef struct packed {
      logic    wrap;
      rob_id_t idx;
   } rob_ptr_t;

   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [XLEN-1:0]       xlen_t;

   // Per-entry lifecycle
   typedef enum logic [1:0] {
      ENT_FREE = 2'd0,
      ENT_WAIT = 2'd1,
      ENT_DONE = 2'd2
   } ent_state_e;

   // Instruction class, only branches can redirect
   typedef enum logic {
      KIND_ALU    = 1'b0,
      KIND_BRANCH = 1'b1
   } ent_kind_e;

endpackage
